// File: all.f
qsim_mem_pkg.sv
qsim_arith_pkg.sv
qsim_sequencer.sv
qsim_complex_mac.sv
qsim_result_writer.sv
qsim_top.sv
qsim_asserts.sv
qsim_tb.sv

// File: qsim_arith_pkg.sv
package qsim_arith_pkg;

  // ------------------------------------------------------------
  // Fixed-point complex format
  // ------------------------------------------------------------
  localparam int PART_W    = 16;
  localparam int FRAC_BITS = 14;

  // Headroom for up to eight summed complex products
  localparam int ACC_W = 36;

  // Real part in the upper half, imaginary part in the lower half
  typedef logic [2*PART_W-1:0] cplx_t;

  typedef logic signed [PART_W-1:0]   part_t;
  typedef logic signed [2*PART_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

endpackage

// File: qsim_asserts.sv
module qsim_asserts (
  input logic clk,
  input logic reset_n,
  input logic dut_valid,
  input logic dut_ready,
  input logic scratch_we,
  input logic out_we
);
  timeunit 1ns;
  timeprecision 1ps;

  logic saw_out_write;

  // Set once the running job has written an output word
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      saw_out_write <= 1'b0;
    end else if (dut_valid && dut_ready) begin
      saw_out_write <= 1'b0;
    end else if (out_we) begin
      saw_out_write <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Write and handshake rules
  // ------------------------------------------------------------
  single_write_dest: assert property (@(posedge clk) disable iff (!reset_n)
    !(scratch_we && out_we))
    else $error("scratch_we and out_we high in the same cycle");

  no_write_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
    !(dut_ready && (scratch_we || out_we)))
    else $error("write enable high while dut_ready is high");

  ready_drops_on_start: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |=> !dut_ready)
    else $error("dut_ready did not drop after a start");

  ready_after_output: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(dut_ready) |-> saw_out_write)
    else $error("dut_ready rose before any output write");

endmodule

// File: qsim_complex_mac.sv
module qsim_complex_mac (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   issue_valid,
  input  logic                   issue_first,
  input  logic                   issue_last,
  input  logic                   row_first,
  input  logic                   use_scratch,
  input  qsim_arith_pkg::cplx_t  gate_rdata,
  input  qsim_arith_pkg::cplx_t  input_rdata,
  input  qsim_arith_pkg::cplx_t  scratch_rdata,
  output logic                   row_valid,
  output logic                   row_first_out,
  output qsim_arith_pkg::cplx_t  row_data
);

  logic                   valid_d1;
  logic                   first_d1;
  logic                   last_d1;
  logic                   row_first_d1;
  logic                   scratch_d1;

  qsim_arith_pkg::cplx_t  state_op;
  qsim_arith_pkg::part_t  g_re, g_im, s_re, s_im;
  qsim_arith_pkg::prod_t  ac, bd, ad, bc;
  qsim_arith_pkg::acc_t   sum_re, sum_im;
  qsim_arith_pkg::acc_t   shr_re, shr_im;
  qsim_arith_pkg::acc_t   acc_re, acc_im;

  // Flags line up with the SRAM read data one cycle later
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_d1     <= 1'b0;
      first_d1     <= 1'b0;
      last_d1      <= 1'b0;
      row_first_d1 <= 1'b0;
      scratch_d1   <= 1'b0;
    end else begin
      valid_d1     <= issue_valid;
      first_d1     <= issue_first;
      last_d1      <= issue_last;
      row_first_d1 <= row_first;
      scratch_d1   <= use_scratch;
    end
  end

  // ------------------------------------------------------------
  // Complex product (a+bi)(c+di)
  // ------------------------------------------------------------
  always_comb begin
    state_op = scratch_d1 ? scratch_rdata : input_rdata;
    g_re = gate_rdata[31:16];
    g_im = gate_rdata[15:0];
    s_re = state_op[31:16];
    s_im = state_op[15:0];
    ac = g_re * s_re;
    bd = g_im * s_im;
    ad = g_re * s_im;
    bc = g_im * s_re;
    sum_re = qsim_arith_pkg::acc_t'(ac) - qsim_arith_pkg::acc_t'(bd);
    sum_im = qsim_arith_pkg::acc_t'(ad) + qsim_arith_pkg::acc_t'(bc);
    if (!first_d1) begin
      sum_re = sum_re + acc_re;
      sum_im = sum_im + acc_im;
    end
    shr_re = sum_re >>> qsim_arith_pkg::FRAC_BITS;
    shr_im = sum_im >>> qsim_arith_pkg::FRAC_BITS;
  end

  always_ff @(posedge clk) begin
    if (valid_d1) begin
      acc_re <= sum_re;
      acc_im <= sum_im;
    end
    if (valid_d1 && last_d1) begin
      row_data <= {shr_re[15:0], shr_im[15:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      row_valid     <= 1'b0;
      row_first_out <= 1'b0;
    end else begin
      row_valid <= valid_d1 && last_d1;
      if (valid_d1 && last_d1) begin
        row_first_out <= row_first_d1;
      end
    end
  end

endmodule

// File: qsim_mem_pkg.sv
package qsim_mem_pkg;

  // ------------------------------------------------------------
  // Address and header field widths
  // ------------------------------------------------------------
  localparam int ADDR_W  = 16;
  localparam int COUNT_W = 16;

  typedef logic [ADDR_W-1:0]  sram_addr_t;
  typedef logic [COUNT_W-1:0] count_t;

  // Supported problem size
  localparam int MAX_QUBITS = 3;
  localparam int MAX_GATES  = 4;
  localparam int MAX_STATES = 8;

  localparam int IDX_W  = $clog2(MAX_STATES);
  localparam int GATE_W = $clog2(MAX_GATES);

  // Row or column index within one state vector
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [GATE_W-1:0] gate_idx_t;

  // ------------------------------------------------------------
  // SRAM layout
  // ------------------------------------------------------------
  // Input SRAM holds the header, then state entry c at c+1
  localparam sram_addr_t HEADER_ADDR = 16'd0;

  // Scratchpad bank b starts at b * SCRATCH_BANK_SIZE
  localparam sram_addr_t SCRATCH_BANK_SIZE = 16'd8;

  // Idle cycles between gates so scratchpad writes land before reads
  localparam int PIPE_DRAIN = 4;
  localparam int DRAIN_W    = $clog2(PIPE_DRAIN);

  typedef logic [DRAIN_W-1:0] drain_t;

endpackage

// File: qsim_result_writer.sv
module qsim_result_writer (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      row_valid,
  input  logic                      row_first_out,
  input  qsim_arith_pkg::cplx_t     row_data,
  input  logic                      to_output,
  input  logic                      bank_sel,
  output logic                      scratch_we,
  output qsim_mem_pkg::sram_addr_t  scratch_waddr,
  output qsim_arith_pkg::cplx_t     scratch_wdata,
  output logic                      out_we,
  output qsim_mem_pkg::sram_addr_t  out_waddr,
  output qsim_arith_pkg::cplx_t     out_wdata
);

  qsim_mem_pkg::idx_t        row_cnt;
  qsim_mem_pkg::idx_t        row_idx;
  qsim_mem_pkg::sram_addr_t  wr_addr;
  qsim_arith_pkg::cplx_t     wr_data;

  // First row of a gate restarts the count
  assign row_idx = row_first_out ? '0 : row_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      scratch_we <= 1'b0;
      out_we     <= 1'b0;
      row_cnt    <= '0;
    end else begin
      scratch_we <= row_valid && !to_output;
      out_we     <= row_valid && to_output;
      if (row_valid) begin
        row_cnt <= row_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      wr_data <= row_data;
      if (to_output) begin
        wr_addr <= qsim_mem_pkg::sram_addr_t'(row_idx);
      end else begin
        wr_addr <= qsim_mem_pkg::sram_addr_t'(bank_sel) * qsim_mem_pkg::SCRATCH_BANK_SIZE +
                   qsim_mem_pkg::sram_addr_t'(row_idx);
      end
    end
  end

  assign scratch_waddr = wr_addr;
  assign scratch_wdata = wr_data;
  assign out_waddr     = wr_addr;
  assign out_wdata     = wr_data;

endmodule

// File: qsim_sequencer.sv
module qsim_sequencer (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        dut_valid,
  output logic                        dut_ready,
  output qsim_mem_pkg::sram_addr_t    input_raddr,
  input  qsim_arith_pkg::cplx_t       input_rdata,
  output qsim_mem_pkg::sram_addr_t    gate_raddr,
  output qsim_mem_pkg::sram_addr_t    scratch_raddr,
  output logic                        issue_valid,
  output logic                        issue_first,
  output logic                        issue_last,
  output logic                        row_first,
  output logic                        use_scratch,
  output logic                        to_output,
  output logic                        bank_sel
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_RUN,
    S_DRAIN,
    S_DONE
  } state_t;

  state_t                    state;
  logic                      hdr_wait;
  qsim_mem_pkg::count_t      q_r;
  qsim_mem_pkg::idx_t        n_last;
  qsim_mem_pkg::gate_idx_t   m_last;
  qsim_mem_pkg::idx_t        col_cnt;
  qsim_mem_pkg::idx_t        row_cnt;
  qsim_mem_pkg::gate_idx_t   gate_cnt;
  qsim_mem_pkg::drain_t      drain_cnt;

  qsim_mem_pkg::count_t      q_hdr;
  qsim_mem_pkg::count_t      m_hdr;
  qsim_mem_pkg::count_t      q_use;
  qsim_mem_pkg::count_t      m_use;
  logic                      last_gate;
  logic                      rd_bank;

  // ------------------------------------------------------------
  // Header decode, clamped to the supported size
  // ------------------------------------------------------------
  always_comb begin
    q_hdr = input_rdata[31:16];
    m_hdr = input_rdata[15:0];
    q_use = (q_hdr > qsim_mem_pkg::count_t'(qsim_mem_pkg::MAX_QUBITS)) ?
            qsim_mem_pkg::count_t'(qsim_mem_pkg::MAX_QUBITS) : q_hdr;
    if (m_hdr == '0) begin
      m_use = 16'd1;
    end else if (m_hdr > qsim_mem_pkg::count_t'(qsim_mem_pkg::MAX_GATES)) begin
      m_use = qsim_mem_pkg::count_t'(qsim_mem_pkg::MAX_GATES);
    end else begin
      m_use = m_hdr;
    end
  end

  assign last_gate = (gate_cnt == m_last);

  // ------------------------------------------------------------
  // FSM and counters
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= S_IDLE;
      dut_ready <= 1'b1;
      hdr_wait  <= 1'b0;
      q_r       <= '0;
      n_last    <= '0;
      m_last    <= '0;
      col_cnt   <= '0;
      row_cnt   <= '0;
      gate_cnt  <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (dut_valid) begin
            dut_ready <= 1'b0;
            hdr_wait  <= 1'b0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            gate_cnt  <= '0;
            state     <= S_HEADER;
          end
        end
        S_HEADER: begin
          // Header data arrives on the second edge
          if (!hdr_wait) begin
            hdr_wait <= 1'b1;
          end else begin
            q_r    <= q_use;
            n_last <= qsim_mem_pkg::idx_t'((1 << q_use) - 1);
            m_last <= qsim_mem_pkg::gate_idx_t'(m_use - 16'd1);
            state  <= S_RUN;
          end
        end
        S_RUN: begin
          if (col_cnt == n_last) begin
            col_cnt <= '0;
            if (row_cnt == n_last) begin
              row_cnt   <= '0;
              drain_cnt <= '0;
              state     <= S_DRAIN;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
        S_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          // Last gate only waits for its final write to reach the bus
          if (last_gate && drain_cnt == qsim_mem_pkg::drain_t'(1)) begin
            state <= S_DONE;
          end else if (!last_gate &&
                       drain_cnt == qsim_mem_pkg::drain_t'(qsim_mem_pkg::PIPE_DRAIN - 1)) begin
            gate_cnt <= gate_cnt + 1'b1;
            state    <= S_RUN;
          end
        end
        S_DONE: begin
          dut_ready <= 1'b1;
          state     <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Issue flags and read addressing
  // ------------------------------------------------------------
  assign issue_valid = (state == S_RUN);
  assign issue_first = issue_valid && (col_cnt == '0);
  assign issue_last  = issue_valid && (col_cnt == n_last);
  assign row_first   = issue_valid && (row_cnt == '0);
  assign use_scratch = (gate_cnt != '0);
  assign to_output   = last_gate;
  assign bank_sel    = gate_cnt[0];

  // Gate j reads the bank written by gate j-1
  assign rd_bank = ~gate_cnt[0];

  assign input_raddr = issue_valid ?
                       qsim_mem_pkg::sram_addr_t'(col_cnt) + 16'd1 :
                       qsim_mem_pkg::HEADER_ADDR;

  assign gate_raddr = (qsim_mem_pkg::sram_addr_t'(gate_cnt) << (2 * q_r)) +
                      (qsim_mem_pkg::sram_addr_t'(row_cnt) << q_r) +
                      qsim_mem_pkg::sram_addr_t'(col_cnt);

  assign scratch_raddr = qsim_mem_pkg::sram_addr_t'(rd_bank) * qsim_mem_pkg::SCRATCH_BANK_SIZE +
                         qsim_mem_pkg::sram_addr_t'(col_cnt);

endmodule

// File: qsim_tb.sv
module qsim_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam int GATE_WORDS = qsim_mem_pkg::MAX_GATES * qsim_mem_pkg::MAX_STATES *
                              qsim_mem_pkg::MAX_STATES;

  logic                      clk;
  logic                      reset_n;
  logic                      dut_valid;
  logic                      dut_ready;
  qsim_mem_pkg::sram_addr_t  input_raddr;
  qsim_mem_pkg::sram_addr_t  gate_raddr;
  qsim_mem_pkg::sram_addr_t  scratch_raddr;
  qsim_mem_pkg::sram_addr_t  scratch_waddr;
  qsim_mem_pkg::sram_addr_t  out_waddr;
  qsim_arith_pkg::cplx_t     input_rdata = '0;
  qsim_arith_pkg::cplx_t     gate_rdata = '0;
  qsim_arith_pkg::cplx_t     scratch_rdata = '0;
  qsim_arith_pkg::cplx_t     scratch_wdata;
  qsim_arith_pkg::cplx_t     out_wdata;
  logic                      scratch_we;
  logic                      out_we;

  qsim_arith_pkg::cplx_t     input_mem [0:15];
  qsim_arith_pkg::cplx_t     gate_mem [0:GATE_WORDS-1];
  qsim_arith_pkg::cplx_t     scratch_mem [0:15];
  qsim_arith_pkg::cplx_t     out_mem [0:qsim_mem_pkg::MAX_STATES-1];
  int                        out_writes = 0;

  int                        cur_q;
  int                        cur_m;
  int                        cur_n;
  int                        writes_at_start;
  bit                        check_armed;
  bit                        check_done;
  bit                        timed_out;
  int                        error_count;
  int                        errors_before;
  int                        tests_run;
  int                        tests_failed;
  qsim_arith_pkg::cplx_t     expected_word;

  qsim_top UUT (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .dut_ready     (dut_ready),
    .input_raddr   (input_raddr),
    .input_rdata   (input_rdata),
    .gate_raddr    (gate_raddr),
    .gate_rdata    (gate_rdata),
    .scratch_we    (scratch_we),
    .scratch_waddr (scratch_waddr),
    .scratch_wdata (scratch_wdata),
    .scratch_raddr (scratch_raddr),
    .scratch_rdata (scratch_rdata),
    .out_we        (out_we),
    .out_waddr     (out_waddr),
    .out_wdata     (out_wdata)
  );

  bind qsim_top qsim_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .dut_valid  (dut_valid),
    .dut_ready  (dut_ready),
    .scratch_we (scratch_we),
    .out_we     (out_we)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // ------------------------------------------------------------
  // SRAM models, one-cycle registered reads
  // ------------------------------------------------------------
  always @(posedge clk) begin
    input_rdata   <= input_mem[input_raddr[3:0]];
    gate_rdata    <= gate_mem[gate_raddr[7:0]];
    scratch_rdata <= scratch_mem[scratch_raddr[3:0]];
    if (scratch_we) begin
      scratch_mem[scratch_waddr[3:0]] <= scratch_wdata;
    end
    if (out_we) begin
      out_mem[out_waddr[2:0]] <= out_wdata;
      out_writes <= out_writes + 1;
    end
  end

  function automatic logic [15:0] random_part();
    int v;
    // Roughly -0.5 to +0.5 in Q2.14
    v = int'($urandom_range(16384, 0)) - 8192;
    return v[15:0];
  endfunction

  // Expected output entry r after m gates, Q2.14 with full-width sums
  function automatic qsim_arith_pkg::cplx_t reference_output(input int q, input int m,
                                                            input int r);
    qsim_arith_pkg::cplx_t cur [0:7];
    qsim_arith_pkg::cplx_t nxt [0:7];
    qsim_arith_pkg::cplx_t g;
    qsim_arith_pkg::cplx_t s;
    longint sum_re;
    longint sum_im;
    longint a;
    longint b;
    longint c;
    longint d;
    int n;
    n = 1 << q;
    for (int i = 0; i < n; i++) begin
      cur[i] = input_mem[i + 1];
    end
    for (int k = 0; k < m; k++) begin
      for (int i = 0; i < n; i++) begin
        sum_re = 0;
        sum_im = 0;
        for (int j = 0; j < n; j++) begin
          g = gate_mem[k * n * n + i * n + j];
          s = cur[j];
          a = longint'($signed(g[31:16]));
          b = longint'($signed(g[15:0]));
          c = longint'($signed(s[31:16]));
          d = longint'($signed(s[15:0]));
          sum_re = sum_re + a * c - b * d;
          sum_im = sum_im + a * d + b * c;
        end
        sum_re = sum_re >>> qsim_arith_pkg::FRAC_BITS;
        sum_im = sum_im >>> qsim_arith_pkg::FRAC_BITS;
        nxt[i] = {sum_re[15:0], sum_im[15:0]};
      end
      cur = nxt;
    end
    return cur[r];
  endfunction

  // Compares the output SRAM once the job has ended
  always @(negedge clk) begin
    if (check_armed && dut_ready) begin
      for (int r = 0; r < cur_n; r++) begin
        expected_word = reference_output(cur_q, cur_m, r);
        assert (out_mem[r] === expected_word) else begin
          $display("ERROR: out_wdata at address %0d is %h, expected %h",
                   r, out_mem[r], expected_word);
          error_count++;
        end
      end
      assert (out_writes - writes_at_start == cur_n) else begin
        $display("Wrong number of output writes: %0d instead of %0d",
                 out_writes - writes_at_start, cur_n);
        error_count++;
      end
      check_armed = 1'b0;
      check_done  = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic load_random_state(input int n);
    for (int c = 0; c < n; c++) begin
      input_mem[c + 1] = {random_part(), random_part()};
    end
  endtask

  task automatic load_identity_gate(input int n);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        gate_mem[r * n + c] = (r == c) ? 32'h4000_0000 : 32'h0;
      end
    end
  endtask

  task automatic load_random_gates(input int n, input int m);
    for (int w = 0; w < m * n * n; w++) begin
      gate_mem[w] = {random_part(), random_part()};
    end
  endtask

  task automatic run_job(input int q, input int m, input bit mid_pulse);
    int cycles;
    @(posedge clk);
    #1;
    cycles = 0;
    while (!dut_ready && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!dut_ready) begin
      $display("Timeout: dut_ready never went high before a start");
      timed_out = 1'b1;
      return;
    end
    input_mem[0] = {16'(q), 16'(m)};
    cur_q = q;
    cur_m = m;
    cur_n = 1 << q;
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    dut_valid = 1'b0;
    assert (!dut_ready) else begin
      $display("dut_ready stayed high after a start");
      error_count++;
    end
    writes_at_start = out_writes;
    check_done  = 1'b0;
    check_armed = 1'b1;
    if (mid_pulse) begin
      // Stray start while the last gate writes its output
      cycles = 0;
      while (!out_we && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!out_we) begin
        $display("Timeout: no output write seen before the stray start");
        timed_out = 1'b1;
        return;
      end
      dut_valid = 1'b1;
      @(posedge clk);
      #1;
      dut_valid = 1'b0;
    end
    cycles = 0;
    while (!check_done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!check_done) begin
      $display("Timeout: job with q=%0d m=%0d never finished", q, m);
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count != errors_before || timed_out) begin
      tests_failed++;
      $display("Test %0d (%s): FAILED", tests_run, name);
    end else begin
      $display("Test %0d (%s): ok", tests_run, name);
    end
    errors_before = error_count;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'hc0a2cb8f));
    reset_n       = 1'b0;
    dut_valid     = 1'b0;
    check_armed   = 1'b0;
    check_done    = 1'b0;
    timed_out     = 1'b0;
    error_count   = 0;
    errors_before = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;

    load_identity_gate(2);
    load_random_state(2);
    run_job(1, 1, 1'b0);
    finish_test("identity gate q=1 m=1");

    if (!timed_out) begin
      load_random_gates(4, 1);
      load_random_state(4);
      run_job(2, 1, 1'b0);
      finish_test("random gate q=2 m=1");
    end

    if (!timed_out) begin
      load_random_gates(8, 4);
      load_random_state(8);
      run_job(3, 4, 1'b0);
      finish_test("chained gates q=3 m=4");
    end

    if (!timed_out) begin
      load_random_gates(8, 2);
      load_random_state(8);
      run_job(3, 2, 1'b0);
      assert (dut_ready) else begin
        $display("dut_ready low between back-to-back jobs");
        error_count++;
      end
      load_random_gates(2, 3);
      load_random_state(2);
      if (!timed_out) begin
        run_job(1, 3, 1'b0);
      end
      finish_test("back-to-back jobs");
    end

    if (!timed_out) begin
      load_random_gates(4, 2);
      load_random_state(4);
      run_job(2, 2, 1'b1);
      // A stray start would pull dut_ready low again
      repeat (3) begin
        @(posedge clk);
        #1;
        assert (dut_ready) else begin
          $display("dut_ready dropped after the job ended");
          error_count++;
        end
      end
      finish_test("dut_valid ignored while busy");
    end

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: qsim_top.sv
module qsim_top (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      dut_valid,
  output logic                      dut_ready,
  output qsim_mem_pkg::sram_addr_t  input_raddr,
  input  qsim_arith_pkg::cplx_t     input_rdata,
  output qsim_mem_pkg::sram_addr_t  gate_raddr,
  input  qsim_arith_pkg::cplx_t     gate_rdata,
  output logic                      scratch_we,
  output qsim_mem_pkg::sram_addr_t  scratch_waddr,
  output qsim_arith_pkg::cplx_t     scratch_wdata,
  output qsim_mem_pkg::sram_addr_t  scratch_raddr,
  input  qsim_arith_pkg::cplx_t     scratch_rdata,
  output logic                      out_we,
  output qsim_mem_pkg::sram_addr_t  out_waddr,
  output qsim_arith_pkg::cplx_t     out_wdata
);

  logic                   issue_valid;
  logic                   issue_first;
  logic                   issue_last;
  logic                   row_first;
  logic                   use_scratch;
  logic                   to_output;
  logic                   bank_sel;
  logic                   row_valid;
  logic                   row_first_out;
  qsim_arith_pkg::cplx_t  row_data;

  // ------------------------------------------------------------
  // Control path
  // ------------------------------------------------------------
  qsim_sequencer u_sequencer (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .dut_ready     (dut_ready),
    .input_raddr   (input_raddr),
    .input_rdata   (input_rdata),
    .gate_raddr    (gate_raddr),
    .scratch_raddr (scratch_raddr),
    .issue_valid   (issue_valid),
    .issue_first   (issue_first),
    .issue_last    (issue_last),
    .row_first     (row_first),
    .use_scratch   (use_scratch),
    .to_output     (to_output),
    .bank_sel      (bank_sel)
  );

  // ------------------------------------------------------------
  // MAC datapath and write-back
  // ------------------------------------------------------------
  qsim_complex_mac u_mac (
    .clk           (clk),
    .reset_n       (reset_n),
    .issue_valid   (issue_valid),
    .issue_first   (issue_first),
    .issue_last    (issue_last),
    .row_first     (row_first),
    .use_scratch   (use_scratch),
    .gate_rdata    (gate_rdata),
    .input_rdata   (input_rdata),
    .scratch_rdata (scratch_rdata),
    .row_valid     (row_valid),
    .row_first_out (row_first_out),
    .row_data      (row_data)
  );

  qsim_result_writer u_writer (
    .clk           (clk),
    .reset_n       (reset_n),
    .row_valid     (row_valid),
    .row_first_out (row_first_out),
    .row_data      (row_data),
    .to_output     (to_output),
    .bank_sel      (bank_sel),
    .scratch_we    (scratch_we),
    .scratch_waddr (scratch_waddr),
    .scratch_wdata (scratch_wdata),
    .out_we        (out_we),
    .out_waddr     (out_waddr),
    .out_wdata     (out_wdata)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module qsim_tb -f all.f -o qsim_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/qsim_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
